/* design/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ########################################
// Datapath sizes
// ########################################

// Shared bus and register width
`define CPU_DATA_WIDTH 32

// General registers r0 to r15
`define CPU_REG_COUNT 16

// ########################################
// Program memory
// ########################################

`define CPU_MEM_DEPTH 512
`define CPU_ADDR_WIDTH 9

`endif

/* design/isaPkg.sv */
package isaPkg;

    // ########################################
    // Opcodes in IR bits 31..27
    // ########################################

    typedef enum logic [4:0] {
        OpLdi  = 5'd0,
        OpAdd  = 5'd1,
        OpSub  = 5'd2,
        OpAnd  = 5'd3,
        OpOr   = 5'd4,
        OpMul  = 5'd5,
        OpMfhi = 5'd6,
        OpMflo = 5'd7,
        OpOut  = 5'd8,
        OpHalt = 5'd9
    } opcodeT;

    // Top bit of each instruction field
    localparam int OpcodeMsb  = 31;
    localparam int RaMsb      = 26;
    localparam int RbMsb      = 22;
    localparam int RcMsb      = 18;
    localparam int ConstWidth = 19; // Constant C sits in bits 18..0

endpackage

/* design/controlPkg.sv */
package controlPkg;

    // ########################################
    // Sequencer states
    // ########################################

    typedef enum logic [3:0] {
        Idle    = 4'd0,
        T0      = 4'd1,
        T1      = 4'd2,
        T2      = 4'd3,
        T3      = 4'd4,
        T4      = 4'd5,
        T5      = 4'd6,
        T6      = 4'd7,
        T7      = 4'd8,
        Stopped = 4'd9
    } seqStateT;

    // ALU operations chosen by the sequencer in T4
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluMul = 3'd4
    } aluOpT;

endpackage

/* design/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       Gra,
    input  logic                       Grb,
    input  logic                       Grc,
    input  logic                       Rin,
    input  logic [`CPU_DATA_WIDTH-1:0] ir,
    input  logic [`CPU_DATA_WIDTH-1:0] busData,
    output logic [`CPU_DATA_WIDTH-1:0] regData
);

    localparam int IdxWidth = $clog2(`CPU_REG_COUNT);

    logic [`CPU_DATA_WIDTH-1:0] regs [0:`CPU_REG_COUNT-1];
    logic [IdxWidth-1:0]        regIdx;

    always_comb begin
        regIdx = '0; // No select means r0
        if (Gra) begin
            regIdx = ir[isaPkg::RaMsb -: IdxWidth];
        end else if (Grb) begin
            regIdx = ir[isaPkg::RbMsb -: IdxWidth];
        end else if (Grc) begin
            regIdx = ir[isaPkg::RcMsb -: IdxWidth];
        end
    end

    always_ff @(posedge Clock) begin
        if (Rin && (regIdx != '0)) begin
            regs[regIdx] <= busData;
        end
    end

    assign regData = (regIdx == '0) ? '0 : regs[regIdx]; // r0 is hardwired to zero

    // The sequencer must never select two IR fields at once
    oneFieldSelect: assert property (@(posedge Clock) disable iff (!arstN)
        $onehot0({Gra, Grb, Grc}));

endmodule

/* design/busEncoder.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module busEncoder (
    input  logic                       PCout,
    input  logic                       MDRout,
    input  logic                       HIout,
    input  logic                       LOout,
    input  logic                       ZhighOut,
    input  logic                       ZlowOut,
    input  logic                       Rout,
    input  logic                       Cout,
    input  logic [`CPU_DATA_WIDTH-1:0] pc,
    input  logic [`CPU_DATA_WIDTH-1:0] mdr,
    input  logic [`CPU_DATA_WIDTH-1:0] hi,
    input  logic [`CPU_DATA_WIDTH-1:0] lo,
    input  logic [`CPU_DATA_WIDTH-1:0] zHigh,
    input  logic [`CPU_DATA_WIDTH-1:0] zLow,
    input  logic [`CPU_DATA_WIDTH-1:0] regData,
    input  logic [`CPU_DATA_WIDTH-1:0] ir,
    output logic [`CPU_DATA_WIDTH-1:0] busData
);

    localparam int ExtBits = `CPU_DATA_WIDTH - isaPkg::ConstWidth;

    logic [`CPU_DATA_WIDTH-1:0] constExt;

    assign constExt = {{ExtBits{ir[isaPkg::ConstWidth-1]}}, ir[isaPkg::ConstWidth-1:0]};

    // One-hot AND-OR mux that idles the bus at zero
    assign busData = ({`CPU_DATA_WIDTH{PCout}}    & pc)
                   | ({`CPU_DATA_WIDTH{MDRout}}   & mdr)
                   | ({`CPU_DATA_WIDTH{HIout}}    & hi)
                   | ({`CPU_DATA_WIDTH{LOout}}    & lo)
                   | ({`CPU_DATA_WIDTH{ZhighOut}} & zHigh)
                   | ({`CPU_DATA_WIDTH{ZlowOut}}  & zLow)
                   | ({`CPU_DATA_WIDTH{Rout}}     & regData)
                   | ({`CPU_DATA_WIDTH{Cout}}     & constExt);

    busGrantOneHot: assert final ($onehot0({PCout, MDRout, HIout, LOout,
                                            ZhighOut, ZlowOut, Rout, Cout}));

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module aluUnit (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       Yin,
    input  logic                       Zin,
    input  controlPkg::aluOpT          aluOp,
    input  logic [`CPU_DATA_WIDTH-1:0] busData,
    output logic [`CPU_DATA_WIDTH-1:0] zHigh,
    output logic [`CPU_DATA_WIDTH-1:0] zLow
);

    localparam int ZWidth = 2 * `CPU_DATA_WIDTH;

    logic [`CPU_DATA_WIDTH-1:0] y;
    logic [ZWidth-1:0]          z;
    logic [ZWidth-1:0]          result;
    logic signed [ZWidth-1:0]   product;

    assign product = $signed(y) * $signed(busData); // Full signed 64-bit product

    always_comb begin
        case (aluOp)
            controlPkg::AluAdd: result = {{`CPU_DATA_WIDTH{1'b0}}, y + busData};
            controlPkg::AluSub: result = {{`CPU_DATA_WIDTH{1'b0}}, y - busData};
            controlPkg::AluAnd: result = {{`CPU_DATA_WIDTH{1'b0}}, y & busData};
            controlPkg::AluOr:  result = {{`CPU_DATA_WIDTH{1'b0}}, y | busData};
            controlPkg::AluMul: result = product;
            default:            result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
            z <= '0;
        end else begin
            if (Yin) begin
                y <= busData; // First operand
            end
            if (Zin) begin
                z <= result;
            end
        end
    end

    assign zHigh = z[ZWidth-1:`CPU_DATA_WIDTH];
    assign zLow  = z[`CPU_DATA_WIDTH-1:0];

endmodule

/* design/memoryInterface.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memoryInterface (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       MARin,
    input  logic                       MDRin,
    input  logic                       Read,
    input  logic                       Running,
    input  logic                       progWrite,
    input  logic [`CPU_ADDR_WIDTH-1:0] progAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] progData,
    input  logic [`CPU_DATA_WIDTH-1:0] busData,
    output logic [`CPU_DATA_WIDTH-1:0] mdr
);

    logic [`CPU_DATA_WIDTH-1:0] ram [0:`CPU_MEM_DEPTH-1];
    logic [`CPU_ADDR_WIDTH-1:0] mar;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
        end else if (MARin) begin
            mar <= busData[`CPU_ADDR_WIDTH-1:0]; // Upper address bits are ignored
        end
    end

    // ########################################
    // RAM with the loader write port
    // ########################################

    always_ff @(posedge Clock) begin
        if (progWrite && !Running) begin
            ram[progAddr] <= progData;
        end
    end

    // Read data lands in MDR one cycle after MAR was loaded
    always_ff @(posedge Clock) begin
        if (MDRin) begin
            mdr <= Read ? ram[mar] : busData;
        end
    end

    // The loader and the CPU share the RAM only by taking turns
    noLoadWhileRunning: assert property (@(posedge Clock) disable iff (!arstN)
        !(progWrite && Running));

endmodule

/* design/specialRegisters.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module specialRegisters (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       PCin,
    input  logic                       IncPC,
    input  logic                       pcClear,
    input  logic                       IRin,
    input  logic                       HIin,
    input  logic                       LOin,
    input  logic                       OutPortin,
    input  logic [`CPU_DATA_WIDTH-1:0] busData,
    output logic [`CPU_DATA_WIDTH-1:0] pc,
    output logic [`CPU_DATA_WIDTH-1:0] ir,
    output logic [`CPU_DATA_WIDTH-1:0] hi,
    output logic [`CPU_DATA_WIDTH-1:0] lo,
    output logic [`CPU_DATA_WIDTH-1:0] outPort,
    output logic                       outValid
);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc       <= '0;
            ir       <= '0;
            hi       <= '0;
            lo       <= '0;
            outPort  <= '0;
            outValid <= 1'b0;
        end else begin
            if (pcClear) begin
                pc <= '0; // Run restarts the program at word 0
            end else if (PCin) begin
                pc <= busData;
            end else if (IncPC) begin
                pc <= pc + 1'b1;
            end
            if (IRin) begin
                ir <= busData;
            end
            if (HIin) begin
                hi <= busData;
            end
            if (LOin) begin
                lo <= busData;
            end
            if (OutPortin) begin
                outPort <= busData;
            end
            outValid <= OutPortin; // One pulse per write that lines up with the new value
        end
    end

endmodule

/* design/controlSequencer.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module controlSequencer (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       Run,
    input  logic [`CPU_DATA_WIDTH-1:0] ir,
    output logic                       PCout,
    output logic                       MDRout,
    output logic                       HIout,
    output logic                       LOout,
    output logic                       ZhighOut,
    output logic                       ZlowOut,
    output logic                       Rout,
    output logic                       Cout,
    output logic                       PCin,
    output logic                       IRin,
    output logic                       MARin,
    output logic                       MDRin,
    output logic                       Yin,
    output logic                       HIin,
    output logic                       LOin,
    output logic                       Rin,
    output logic                       OutPortin,
    output logic                       Zin,
    output logic                       Gra,
    output logic                       Grb,
    output logic                       Grc,
    output logic                       IncPC,
    output logic                       Read,
    output logic                       pcClear,
    output controlPkg::aluOpT          aluOp,
    output logic                       Running,
    output logic                       Halted
);

    controlPkg::seqStateT state;
    controlPkg::seqStateT nextState;
    isaPkg::opcodeT       opcode;

    assign opcode = isaPkg::opcodeT'(ir[isaPkg::OpcodeMsb -: $bits(isaPkg::opcodeT)]);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state  <= controlPkg::Idle;
            Halted <= 1'b0;
        end else begin
            state  <= nextState;
            Halted <= (nextState == controlPkg::Stopped);
        end
    end

    assign Running = (state != controlPkg::Idle) && (state != controlPkg::Stopped);

    // ########################################
    // Strobes and next state
    // ########################################

    always_comb begin
        PCout     = 1'b0;
        MDRout    = 1'b0;
        HIout     = 1'b0;
        LOout     = 1'b0;
        ZhighOut  = 1'b0;
        ZlowOut   = 1'b0;
        Rout      = 1'b0;
        Cout      = 1'b0;
        PCin      = 1'b0; // No jumps in this instruction set
        IRin      = 1'b0;
        MARin     = 1'b0;
        MDRin     = 1'b0;
        Yin       = 1'b0;
        HIin      = 1'b0;
        LOin      = 1'b0;
        Rin       = 1'b0;
        OutPortin = 1'b0;
        Zin       = 1'b0;
        Gra       = 1'b0;
        Grb       = 1'b0;
        Grc       = 1'b0;
        IncPC     = 1'b0;
        Read      = 1'b0;
        pcClear   = 1'b0;
        aluOp     = controlPkg::AluAdd;
        nextState = state;
        case (state)
            controlPkg::Idle, controlPkg::Stopped: begin
                if (Run) begin
                    pcClear   = 1'b1;
                    nextState = controlPkg::T0;
                end
            end
            controlPkg::T0: begin
                PCout     = 1'b1;
                MARin     = 1'b1;
                IncPC     = 1'b1;
                nextState = controlPkg::T1;
            end
            controlPkg::T1: begin
                Read      = 1'b1;
                MDRin     = 1'b1;
                nextState = controlPkg::T2;
            end
            controlPkg::T2: begin
                MDRout    = 1'b1;
                IRin      = 1'b1;
                nextState = controlPkg::T3;
            end
            controlPkg::T3: begin
                nextState = controlPkg::T0;
                case (opcode)
                    isaPkg::OpLdi, isaPkg::OpAdd, isaPkg::OpSub,
                    isaPkg::OpAnd, isaPkg::OpOr: begin
                        Rout      = 1'b1;
                        Grb       = 1'b1;
                        Yin       = 1'b1;
                        nextState = controlPkg::T4;
                    end
                    isaPkg::OpMul: begin
                        Rout      = 1'b1;
                        Gra       = 1'b1;
                        Yin       = 1'b1;
                        nextState = controlPkg::T4;
                    end
                    isaPkg::OpMfhi, isaPkg::OpMflo: begin
                        HIout = (opcode == isaPkg::OpMfhi);
                        LOout = (opcode == isaPkg::OpMflo);
                        Gra   = 1'b1;
                        Rin   = 1'b1;
                    end
                    isaPkg::OpOut: begin
                        Rout      = 1'b1;
                        Gra       = 1'b1;
                        OutPortin = 1'b1;
                    end
                    default: nextState = controlPkg::Stopped; // halt and unknown opcodes
                endcase
            end
            controlPkg::T4: begin
                Cout = (opcode == isaPkg::OpLdi);
                Rout = (opcode != isaPkg::OpLdi);
                Grb  = (opcode == isaPkg::OpMul);
                Grc  = (opcode != isaPkg::OpLdi) && (opcode != isaPkg::OpMul);
                Zin  = 1'b1;
                case (opcode)
                    isaPkg::OpSub: aluOp = controlPkg::AluSub;
                    isaPkg::OpAnd: aluOp = controlPkg::AluAnd;
                    isaPkg::OpOr:  aluOp = controlPkg::AluOr;
                    isaPkg::OpMul: aluOp = controlPkg::AluMul;
                    default:       aluOp = controlPkg::AluAdd;
                endcase
                nextState = controlPkg::T5;
            end
            controlPkg::T5: begin
                ZlowOut = 1'b1;
                if (opcode == isaPkg::OpMul) begin
                    LOin      = 1'b1;
                    nextState = controlPkg::T6;
                end else begin
                    Gra       = 1'b1;
                    Rin       = 1'b1;
                    nextState = controlPkg::T0;
                end
            end
            controlPkg::T6: begin
                ZhighOut  = 1'b1;
                HIin      = 1'b1;
                nextState = controlPkg::T0;
            end
            default: nextState = controlPkg::T0; // T7 is spare
        endcase
    end

    haltedNotRunning: assert property (@(posedge Clock) disable iff (!arstN)
        !(Halted && Running));

endmodule

/* design/cpuTop.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTop (
    input  logic                       Clock,
    input  logic                       arstN,
    input  logic                       Run,
    input  logic                       progWrite,
    input  logic [`CPU_ADDR_WIDTH-1:0] progAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] progData,
    output logic [`CPU_DATA_WIDTH-1:0] outPort,
    output logic                       outValid,
    output logic                       Halted
);

    // ########################################
    // Shared bus and register values
    // ########################################

    logic [`CPU_DATA_WIDTH-1:0] busData;
    logic [`CPU_DATA_WIDTH-1:0] pc;
    logic [`CPU_DATA_WIDTH-1:0] ir;
    logic [`CPU_DATA_WIDTH-1:0] mdr;
    logic [`CPU_DATA_WIDTH-1:0] hi;
    logic [`CPU_DATA_WIDTH-1:0] lo;
    logic [`CPU_DATA_WIDTH-1:0] zHigh;
    logic [`CPU_DATA_WIDTH-1:0] zLow;
    logic [`CPU_DATA_WIDTH-1:0] regData;

    // Bus grants from the sequencer
    logic PCout, MDRout, HIout, LOout;
    logic ZhighOut, ZlowOut, Rout, Cout;

    // Register loads and other control
    logic PCin, IRin, MARin, MDRin, Yin, HIin, LOin, Rin, OutPortin, Zin;
    logic Gra, Grb, Grc, IncPC, Read, pcClear, Running;
    controlPkg::aluOpT aluOp;

    controlSequencer controlSequencer_inst (.*);

    busEncoder busEncoder_inst (.*);

    registerFile registerFile_inst (.*);

    specialRegisters specialRegisters_inst (.*);

    aluUnit aluUnit_inst (.*);

    memoryInterface memoryInterface_inst (.*);

endmodule

/* sim/cpuTop_tb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTop_tb;

    localparam int ResetCycles = 16;
    localparam int FixedRows   = 17;
    localparam int RandomRows  = 6;
    localparam int RowCount    = FixedRows + RandomRows;
    localparam int CycleLimit  = RowCount * 40 + ResetCycles; // Worst row is a mul program
    localparam int CW          = isaPkg::ConstWidth;

    // Each row kind selects a program shape
    localparam int KindLdi   = 0;
    localparam int KindAdd   = 1;
    localparam int KindSub   = 2;
    localparam int KindAnd   = 3;
    localparam int KindOr    = 4;
    localparam int KindMulLo = 5;
    localparam int KindMulHi = 6;
    localparam int KindR0    = 7;

    logic                       Clock;
    logic                       arstN;
    logic                       Run;
    logic                       progWrite;
    logic [`CPU_ADDR_WIDTH-1:0] progAddr;
    logic [`CPU_DATA_WIDTH-1:0] progData;
    logic [`CPU_DATA_WIDTH-1:0] outPort;
    logic                       outValid;
    logic                       Halted;

    // ########################################
    // Stimulus and expected value table
    // ########################################

    string                      rowName   [0:RowCount-1];
    int                         rowKind   [0:RowCount-1];
    logic [CW-1:0]              rowA      [0:RowCount-1];
    logic [CW-1:0]              rowB      [0:RowCount-1];
    logic [`CPU_DATA_WIDTH-1:0] rowExpect [0:RowCount-1];
    int                         rowsFilled;

    logic [`CPU_DATA_WIDTH-1:0] progWords [0:7];
    int                         progLen;
    int                         cycleCount;
    int                         passCount;
    int                         failCount;
    integer                     seed;

    cpuTop cpuTop_inst (
        .Clock     (Clock),
        .arstN     (arstN),
        .Run       (Run),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .outPort   (outPort),
        .outValid  (outValid),
        .Halted    (Halted)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount <= CycleLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("TEST FAILED");
        $finish;
    end

    // Result from the ISA rules on sign-extended 19-bit constants
    function automatic logic [31:0] expectedFor(input int kind, input logic [CW-1:0] a,
                                                input logic [CW-1:0] b);
        logic [31:0] sa;
        logic [31:0] sb;
        logic [63:0] prod;
        sa   = {{(32-CW){a[CW-1]}}, a};
        sb   = {{(32-CW){b[CW-1]}}, b};
        prod = {{32{sa[31]}}, sa} * {{32{sb[31]}}, sb}; // Low 64 bits equal the signed product
        case (kind)
            KindLdi:   return sa;
            KindAdd:   return sa + sb;
            KindSub:   return sa - sb;
            KindAnd:   return sa & sb;
            KindOr:    return sa | sb;
            KindMulLo: return prod[31:0];
            KindMulHi: return prod[63:32];
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] encodeLdi(input logic [3:0] ra, input logic [CW-1:0] c);
        return {isaPkg::OpLdi, ra, 4'd0, c}; // Rb is r0, so Z is 0 plus C
    endfunction

    function automatic logic [31:0] encodeRegs(input isaPkg::opcodeT op, input logic [3:0] ra,
                                               input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic isaPkg::opcodeT aluOpcode(input int kind);
        case (kind)
            KindSub: return isaPkg::OpSub;
            KindAnd: return isaPkg::OpAnd;
            KindOr:  return isaPkg::OpOr;
            default: return isaPkg::OpAdd;
        endcase
    endfunction

    task automatic addRow(input string name, input int kind, input logic [CW-1:0] a,
                          input logic [CW-1:0] b, input logic [31:0] expected);
        rowName[rowsFilled]   = name;
        rowKind[rowsFilled]   = kind;
        rowA[rowsFilled]      = a;
        rowB[rowsFilled]      = b;
        rowExpect[rowsFilled] = expected;
        rowsFilled++;
    endtask

    task automatic fillTable();
        int            kind;
        logic [CW-1:0] a;
        logic [CW-1:0] b;
        addRow("ldiPos",        KindLdi,   19'h00123, 19'h0,     32'h00000123);
        addRow("ldiNeg",        KindLdi,   19'h40000, 19'h0,     32'hFFFC0000);
        addRow("addSmall",      KindAdd,   19'd100,   19'd23,    32'd123);
        addRow("addNegative",   KindAdd,   19'h7FFFB, 19'd3,     32'hFFFFFFFE);
        addRow("subSmall",      KindSub,   19'd1000,  19'd1,     32'd999);
        addRow("subWrap",       KindSub,   19'd0,     19'd1,     32'hFFFFFFFF);
        addRow("subNegative",   KindSub,   19'h40000, 19'h3FFFF, 32'hFFF80001);
        addRow("andMask",       KindAnd,   19'h0F0F0, 19'h0FF00, 32'h0000F000);
        addRow("andNegative",   KindAnd,   19'h7FFFF, 19'h40001, 32'hFFFC0001);
        addRow("orMask",        KindOr,    19'h00F00, 19'h000F0, 32'h00000FF0);
        addRow("mulLoSmall",    KindMulLo, 19'd1000,  19'd2000,  32'h001E8480);
        addRow("mulHiSmall",    KindMulHi, 19'd1000,  19'd2000,  32'h00000000);
        addRow("mulLoNegative", KindMulLo, 19'h7FFFD, 19'd5,     32'hFFFFFFF1);
        addRow("mulHiNegative", KindMulHi, 19'h7FFFD, 19'd5,     32'hFFFFFFFF);
        addRow("mulLoLarge",    KindMulLo, 19'h3FFFF, 19'h3FFFF, 32'hFFF80001);
        addRow("mulHiLarge",    KindMulHi, 19'h3FFFF, 19'h3FFFF, 32'h0000000F);
        addRow("r0Ignored",     KindR0,    19'h12345, 19'h0,     32'h00000000);
        for (int i = 0; i < RandomRows; i++) begin
            kind = KindAdd + ($unsigned($random(seed)) % 6); // Any of add up to mul high
            a    = CW'($random(seed));
            b    = CW'($random(seed));
            addRow($sformatf("random%0d", i), kind, a, b, expectedFor(kind, a, b));
        end
    endtask

    task automatic appendWord(input logic [31:0] word);
        progWords[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram(input int kind, input logic [CW-1:0] a, input logic [CW-1:0] b);
        progLen = 0;
        case (kind)
            KindLdi: begin
                appendWord(encodeLdi(4'd1, a));
                appendWord(encodeRegs(isaPkg::OpOut, 4'd1, 4'd0, 4'd0));
            end
            KindR0: begin
                appendWord(encodeLdi(4'd0, a)); // Write to r0 must be dropped
                appendWord(encodeRegs(isaPkg::OpOut, 4'd0, 4'd0, 4'd0));
            end
            default: begin
                appendWord(encodeLdi(4'd1, a));
                appendWord(encodeLdi(4'd2, b));
                if (kind == KindMulLo || kind == KindMulHi) begin
                    appendWord(encodeRegs(isaPkg::OpMul, 4'd1, 4'd2, 4'd0));
                    appendWord(encodeRegs(kind == KindMulHi ? isaPkg::OpMfhi : isaPkg::OpMflo,
                                          4'd3, 4'd0, 4'd0));
                end else begin
                    appendWord(encodeRegs(aluOpcode(kind), 4'd3, 4'd1, 4'd2));
                end
                appendWord(encodeRegs(isaPkg::OpOut, 4'd3, 4'd0, 4'd0));
            end
        endcase
        appendWord(encodeRegs(isaPkg::OpHalt, 4'd0, 4'd0, 4'd0));
    endtask

    // ########################################
    // Load, run and watch the output port
    // ########################################

    task automatic loadAndRun(output int pulses, output logic [31:0] captured,
                              output bit ranAfterHalt);
        pulses       = 0;
        captured     = '0;
        ranAfterHalt = 1'b0;
        for (int i = 0; i < progLen; i++) begin
            @(negedge Clock);
            progWrite = 1'b1;
            progAddr  = `CPU_ADDR_WIDTH'(i);
            progData  = progWords[i];
        end
        @(negedge Clock);
        progWrite = 1'b0;
        Run       = 1'b1;
        @(negedge Clock);
        Run = 1'b0;
        while (!Halted) begin
            if (outValid) begin
                pulses++;
                captured = outPort;
            end
            @(negedge Clock);
        end
        repeat (2) begin
            @(negedge Clock);
            if (!Halted || outValid || cpuTop_inst.Running) begin
                ranAfterHalt = 1'b1;
            end
        end
    endtask

    task automatic runRow(input int r);
        int          pulses;
        logic [31:0] captured;
        bit          ranAfterHalt;
        buildProgram(rowKind[r], rowA[r], rowB[r]);
        loadAndRun(pulses, captured, ranAfterHalt);
        if (pulses == 0) begin
            $display("Error in %s: no outValid pulse appeared before Halted", rowName[r]);
            failCount++;
        end else if (pulses > 1) begin
            $display("Error in %s: %0d outValid pulses instead of one", rowName[r], pulses);
            failCount++;
        end else if (ranAfterHalt) begin
            $display("Error in %s: the CPU did not stay stopped after halt", rowName[r]);
            failCount++;
        end else if (captured !== rowExpect[r]) begin
            $display("Error: %s expected %h actual %h", rowName[r], rowExpect[r], captured);
            failCount++;
        end else begin
            $display("ok     %s outPort %h", rowName[r], captured);
            passCount++;
        end
    endtask

    task automatic checkReset();
        if (Halted !== 1'b0 || outValid !== 1'b0 || outPort !== '0) begin
            $display("Error: resetState expected Halted 0 outValid 0 outPort %h, %s %b %b %h",
                     32'h0, "actual", Halted, outValid, outPort);
            failCount++;
        end else begin
            $display("ok     resetState");
            passCount++;
        end
    endtask

    initial begin
        seed       = 94606;
        arstN      = 1'b0;
        Run        = 1'b0;
        progWrite  = 1'b0;
        progAddr   = '0;
        progData   = '0;
        passCount  = 0;
        failCount  = 0;
        rowsFilled = 0;
        fillTable();
        repeat (ResetCycles) @(negedge Clock);
        arstN = 1'b1;
        @(negedge Clock);
        checkReset();
        for (int r = 0; r < RowCount; r++) begin
            runRow(r);
        end
        $display("Tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/isaPkg.sv
design/controlPkg.sv
design/registerFile.sv
design/busEncoder.sv
design/aluUnit.sv
design/memoryInterface.sv
design/specialRegisters.sv
design/controlSequencer.sv
design/cpuTop.sv
sim/cpuTop_tb.sv

/* Bender.yml */
package:
  name: cpu_top

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/controlPkg.sv
      - design/registerFile.sv
      - design/busEncoder.sv
      - design/aluUnit.sv
      - design/memoryInterface.sv
      - design/specialRegisters.sv
      - design/controlSequencer.sv
      - design/cpuTop.sv
      - target: test
        files:
          - sim/cpuTop_tb.sv
